// ==== source/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    typedef enum logic [4:0] {
        NOP  = 5'd0,
        INT  = 5'd1,
        PIL  = 5'd2,
        PIS  = 5'd3,
        PIF  = 5'd4,
        PME  = 5'd5,
        PPI  = 5'd6,
        ADEF = 5'd7,
        ADEM = 5'd8,
        ALE  = 5'd9,
        SYS  = 5'd10,
        BRK  = 5'd11,
        INE  = 5'd12,
        IPE  = 5'd13,
        FPD  = 5'd14,
        FPE  = 5'd15,
        TLBR = 5'd16
    } excp_cause_e;

    typedef enum logic [13:0] {
        CRMD   = 14'h0,
        PRMD   = 14'h1,
        ESTAT  = 14'h5,
        ERA    = 14'h6,
        EENTRY = 14'hC
    } csr_addr_e;

    typedef logic [7:0] stage_vec_t; // bit 0 pc ... bit 7 writeback

    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        logic [31:0]       mem_addr;
        logic [5:0]        excp_flags;  // bit 5 earliest stage
        excp_cause_e [5:0] excp_causes; // one cause per stage flag
        logic              is_priv;
        logic              is_ertn;
        logic              is_idle;
        logic              is_llw_scw;
        logic              rf_we;
        logic [4:0]        rf_addr;
        logic [31:0]       rf_data;
        logic              csr_we;
        csr_addr_e         csr_addr;
        logic [31:0]       csr_data;
    } commit_slot_t;

    typedef struct packed {
        logic        is_excp;
        excp_cause_e cause;
        logic [31:0] pc;
        logic [31:0] badv; // memory address of the faulting slot
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } excp_rec_t;

    typedef struct packed {
        logic buffer;
        logic decode;
        logic dispatch;
        logic execute;
        logic mem;
    } pause_req_t;

    // returns {ecode, esubcode}
    function automatic logic [14:0] ecode_of(input excp_cause_e cause);
        logic [5:0] ecode;
        logic [8:0] esubcode;
        esubcode = 9'd0;
        case (cause)
            INT:  ecode = 6'h00;
            PIL:  ecode = 6'h01;
            PIS:  ecode = 6'h02;
            PIF:  ecode = 6'h03;
            PME:  ecode = 6'h04;
            PPI:  ecode = 6'h07;
            ADEF: ecode = 6'h08;
            ADEM: begin
                ecode    = 6'h08;
                esubcode = 9'd1; // data side address error
            end
            ALE:  ecode = 6'h09;
            SYS:  ecode = 6'h0B;
            BRK:  ecode = 6'h0C;
            INE:  ecode = 6'h0D;
            IPE:  ecode = 6'h0E;
            FPD:  ecode = 6'h0F;
            FPE:  ecode = 6'h12;
            TLBR: ecode = 6'h3F;
            default: ecode = 6'h00;
        endcase
        return {ecode, esubcode};
    endfunction

endpackage

`default_nettype wire

// ==== source/excp_prioritizer.sv ====
`timescale 1ns/100ps
`default_nettype none

module excp_prioritizer (
    input  wire commit_pkg::commit_slot_t slot_i,
    input  wire                           int_taken_i,
    input  wire [1:0]                     plv_i,
    output commit_pkg::excp_cause_e       cause_o,
    output logic                          is_excp_o
);
    import commit_pkg::*;

    logic [6:0] req_vec; // interrupt above the six stage flags
    logic       priv_fault;

    assign req_vec    = {int_taken_i, slot_i.excp_flags};
    assign priv_fault = slot_i.is_priv && (plv_i != 2'b00);

    always_comb begin
        cause_o = NOP;
        if (slot_i.valid) begin
            casez (req_vec)
                7'b1??????: cause_o = INT;
                7'b01?????: cause_o = slot_i.excp_causes[5];
                7'b001????: cause_o = slot_i.excp_causes[4];
                7'b0001???: begin
                    // decode stage flag, privileged op outside kernel mode
                    cause_o = priv_fault ? IPE : slot_i.excp_causes[3];
                end
                7'b00001??: cause_o = slot_i.excp_causes[2];
                7'b000001?: cause_o = slot_i.excp_causes[1];
                7'b0000001: cause_o = slot_i.excp_causes[0];
                default:    cause_o = NOP;
            endcase
        end
    end

    assign is_excp_o = slot_i.valid && ((|slot_i.excp_flags) || int_taken_i);

    // upstream stages must never raise a flag with a NOP cause
    always_comb begin
        assert (!is_excp_o || cause_o != NOP)
            else $error("excepting slot resolved to NOP cause");
    end

endmodule

`default_nettype wire

// ==== source/excp_commit_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module excp_commit_unit (
    input  wire commit_pkg::commit_slot_t slot0_i,
    input  wire commit_pkg::commit_slot_t slot1_i,
    input  wire commit_pkg::excp_cause_e  cause0_i,
    input  wire commit_pkg::excp_cause_e  cause1_i,
    input  wire                           excp0_i,
    input  wire                           excp1_i,
    output commit_pkg::excp_rec_t         excp_rec_o
);
    import commit_pkg::*;

    commit_slot_t sel_slot;  // slot that owns the exception
    excp_cause_e  sel_cause;
    logic         any_excp;
    logic [14:0]  codes;     // {ecode, esubcode}

    assign any_excp = excp0_i || excp1_i;

    // older slot always wins
    always_comb begin
        if (excp0_i) begin
            sel_slot  = slot0_i;
            sel_cause = cause0_i;
        end else if (excp1_i) begin
            sel_slot  = slot1_i;
            sel_cause = cause1_i;
        end else begin
            sel_slot  = slot1_i;
            sel_cause = NOP;
        end
    end

    assign codes = ecode_of(sel_cause);

    always_comb begin
        excp_rec_o = '0; // quiet record when nothing excepts
        if (any_excp) begin
            excp_rec_o.is_excp  = 1'b1;
            excp_rec_o.cause    = sel_cause;
            excp_rec_o.pc       = sel_slot.pc;
            excp_rec_o.badv     = sel_slot.mem_addr;
            excp_rec_o.ecode    = codes[14:9];
            excp_rec_o.esubcode = codes[8:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_flush_pause.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_flush_pause (
    input  wire                         excp_i,
    input  wire                         ertn_i,
    input  wire                         refetch_i,
    input  wire [31:0]                  refetch_pc_i,
    input  wire                         branch_flush_i,
    input  wire [31:0]                  branch_target_i,
    input  wire                         ex_excp_flush_i,
    input  wire [31:0]                  eentry_i,
    input  wire [31:0]                  era_i,
    input  wire commit_pkg::pause_req_t pause_req_i,
    input  wire                         idle_i,
    input  wire                         int_taken_i,
    output commit_pkg::stage_vec_t      flush_o,
    output commit_pkg::stage_vec_t      pause_o,
    output logic [31:0]                 new_pc_o
);

    logic       flush_front; // icache and instruction buffer
    logic       flush_back;  // execute, mem, writeback
    logic       flush_mid;   // decode and dispatch also see ex_excp
    logic       idle_stall;
    logic [4:0] pause_back;

    assign flush_front = excp_i || ertn_i || refetch_i;
    assign flush_back  = flush_front || branch_flush_i;
    assign flush_mid   = flush_back || ex_excp_flush_i;

    assign flush_o = {flush_back, flush_back, flush_back,
                      flush_mid, flush_mid,
                      flush_front, flush_front, 1'b0};

    // pending interrupt wakes an idle instruction
    assign idle_stall = idle_i && !int_taken_i;

    always_comb begin
        if (pause_req_i.mem || idle_stall) begin
            pause_back = 5'b01111;
        end else if (pause_req_i.execute) begin
            pause_back = 5'b00111;
        end else if (pause_req_i.dispatch) begin
            pause_back = 5'b00011;
        end else if (pause_req_i.decode) begin
            pause_back = 5'b00001;
        end else begin
            pause_back = 5'b00000;
        end
    end

    assign pause_o = {pause_back, pause_req_i.decode,
                      pause_req_i.buffer && !flush_o[1], pause_req_i.buffer};

    assign new_pc_o = excp_i    ? eentry_i     :
                      ertn_i    ? era_i        :
                      refetch_i ? refetch_pc_i : branch_target_i;

endmodule

`default_nettype wire

// ==== source/commit_write_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_write_filter (
    input  wire commit_pkg::commit_slot_t slot0_i,
    input  wire commit_pkg::commit_slot_t slot1_i,
    input  wire                           excp0_i,
    input  wire                           excp_any_i,
    output logic [1:0]                    rf_we_o,
    output logic [4:0]                    rf_waddr0_o,
    output logic [4:0]                    rf_waddr1_o,
    output logic [31:0]                   rf_wdata0_o,
    output logic [31:0]                   rf_wdata1_o,
    output logic                          csr_we_o,
    output commit_pkg::csr_addr_e         csr_waddr_o,
    output logic [31:0]                   csr_wdata_o,
    output logic                          llw_scw_o,
    output logic                          refetch_o,
    output logic [31:0]                   refetch_pc_o
);

    logic we0_live;
    logic we1_live;
    logic same_dst;
    logic csr_sel0; // slot 0 owns the csr write

    assign we0_live = slot0_i.valid && slot0_i.rf_we && !excp0_i;
    assign we1_live = slot1_i.valid && slot1_i.rf_we && !excp_any_i; // killed by either
    assign same_dst = slot0_i.rf_addr == slot1_i.rf_addr;

    // younger slot 1 result is the one that must land
    assign rf_we_o     = {we1_live, we0_live && !(we1_live && same_dst)};
    assign rf_waddr0_o = slot0_i.rf_addr;
    assign rf_waddr1_o = slot1_i.rf_addr;
    assign rf_wdata0_o = slot0_i.rf_data;
    assign rf_wdata1_o = slot1_i.rf_data;

    assign csr_sel0    = slot0_i.valid && slot0_i.csr_we;
    assign csr_we_o    = (csr_sel0 || (slot1_i.valid && slot1_i.csr_we)) && !excp_any_i;
    assign csr_waddr_o = csr_sel0 ? slot0_i.csr_addr : slot1_i.csr_addr;
    assign csr_wdata_o = csr_sel0 ? slot0_i.csr_data : slot1_i.csr_data;

    assign llw_scw_o = !excp_any_i && ((slot0_i.valid && slot0_i.is_llw_scw) ||
                                       (slot1_i.valid && slot1_i.is_llw_scw));

    // csr side effects need the following instructions fetched again
    assign refetch_o    = csr_we_o;
    assign refetch_pc_o = (slot0_i.pc | slot1_i.pc) + 32'd4;

    // slot 0 exception must be part of the combined flag
    always_comb begin
        assert (!excp0_i || excp_any_i)
            else $error("slot 0 exception missing from the combined exception flag");
    end

endmodule

`default_nettype wire

// ==== source/commit_csr_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_csr_regs #(
    parameter logic [31:0] EENTRY_RST = 32'h1C00_8000
) (
    input  wire                        clk,
    input  wire                        arst_n_i,
    input  wire commit_pkg::excp_rec_t excp_rec_i,
    input  wire                        ertn_i,
    input  wire                        csr_we_i,
    input  wire commit_pkg::csr_addr_e csr_waddr_i,
    input  wire [31:0]                 csr_wdata_i,
    input  wire                        int_pending_i,
    input  wire commit_pkg::csr_addr_e raddr_i,
    output logic [31:0]                rdata_o,
    output logic [31:0]                eentry_o,
    output logic [31:0]                era_o,
    output logic [1:0]                 plv_o,
    output logic                       int_taken_o
);
    import commit_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;  // plv saved on exception entry
    logic        prmd_pie;
    logic [14:0] estat_code; // {esubcode, ecode}
    logic [31:0] era;
    logic [25:0] eentry_base; // 64 byte aligned entry

    // exception beats ertn, ertn beats an explicit write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crmd_plv    <= 2'b00;
            crmd_ie     <= 1'b0;
            prmd_pplv   <= 2'b00;
            prmd_pie    <= 1'b0;
            estat_code  <= '0;
            era         <= '0;
            eentry_base <= EENTRY_RST[31:6];
        end else if (excp_rec_i.is_excp) begin
            era        <= excp_rec_i.pc;
            estat_code <= {excp_rec_i.esubcode, excp_rec_i.ecode};
            prmd_pplv  <= crmd_plv;
            prmd_pie   <= crmd_ie;
            crmd_plv   <= 2'b00; // enter kernel, interrupts masked
            crmd_ie    <= 1'b0;
        end else if (ertn_i) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we_i) begin
            case (csr_waddr_i)
                CRMD: begin
                    crmd_plv <= csr_wdata_i[1:0];
                    crmd_ie  <= csr_wdata_i[2];
                end
                PRMD: begin
                    prmd_pplv <= csr_wdata_i[1:0];
                    prmd_pie  <= csr_wdata_i[2];
                end
                ERA:     era         <= csr_wdata_i;
                EENTRY:  eentry_base <= csr_wdata_i[31:6];
                default: ; // estat code fields are hardware owned
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            CRMD:    rdata_o = {29'd0, crmd_ie, crmd_plv};
            PRMD:    rdata_o = {29'd0, prmd_pie, prmd_pplv};
            ESTAT:   rdata_o = {17'd0, estat_code};
            ERA:     rdata_o = era;
            EENTRY:  rdata_o = eentry_o;
            default: rdata_o = 32'd0;
        endcase
    end

    assign eentry_o    = {eentry_base, 6'd0};
    assign era_o       = era;
    assign plv_o       = crmd_plv;
    assign int_taken_o = int_pending_i && crmd_ie;

    // write filter has to drop csr writes of an excepting commit
    excp_no_csr_wr: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(excp_rec_i.is_excp && csr_we_i));

endmodule

`default_nettype wire

// ==== source/commit_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_ctrl_top #(
    parameter logic [31:0] EENTRY_RST = 32'h1C00_8000
) (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire commit_pkg::commit_slot_t slot0_i,
    input  wire commit_pkg::commit_slot_t slot1_i,
    input  wire commit_pkg::pause_req_t   pause_req_i,
    input  wire                           branch_flush_i,
    input  wire [31:0]                    branch_target_i,
    input  wire                           ex_excp_flush_i,
    input  wire                           int_pending_i,
    input  wire commit_pkg::csr_addr_e    csr_raddr_i,
    output commit_pkg::stage_vec_t        flush_o,
    output commit_pkg::stage_vec_t        pause_o,
    output logic [31:0]                   new_pc_o,
    output logic                          is_ertn_o,
    output logic [1:0]                    rf_we_o,
    output logic [4:0]                    rf_waddr0_o,
    output logic [4:0]                    rf_waddr1_o,
    output logic [31:0]                   rf_wdata0_o,
    output logic [31:0]                   rf_wdata1_o,
    output logic                          llw_scw_o,
    output logic [31:0]                   csr_rdata_o,
    output commit_pkg::excp_rec_t         excp_rec_o
);
    import commit_pkg::*;

    logic        int_taken;
    logic [1:0]  crmd_plv;
    logic [31:0] eentry;
    logic [31:0] era;
    excp_cause_e cause0;
    excp_cause_e cause1;
    logic        excp0;
    logic        excp1;
    logic        ertn;       // only slot 0 may return
    logic        idle;
    logic        refetch;
    logic [31:0] refetch_pc;
    logic        csr_we;
    csr_addr_e   csr_waddr;
    logic [31:0] csr_wdata;

    assign ertn      = slot0_i.valid && slot0_i.is_ertn;
    assign idle      = slot0_i.valid && slot0_i.is_idle;
    assign is_ertn_o = ertn;

    excp_prioritizer u_prio0 (.slot_i(slot0_i), .int_taken_i(int_taken), .plv_i(crmd_plv),
                              .cause_o(cause0), .is_excp_o(excp0));
    excp_prioritizer u_prio1 (.slot_i(slot1_i), .int_taken_i(int_taken), .plv_i(crmd_plv),
                              .cause_o(cause1), .is_excp_o(excp1));

    excp_commit_unit u_excp (.slot0_i(slot0_i), .slot1_i(slot1_i), .cause0_i(cause0),
                             .cause1_i(cause1), .excp0_i(excp0), .excp1_i(excp1),
                             .excp_rec_o(excp_rec_o));

    commit_write_filter u_wfilt (
        .slot0_i(slot0_i), .slot1_i(slot1_i), .excp0_i(excp0),
        .excp_any_i(excp_rec_o.is_excp), .rf_we_o(rf_we_o),
        .rf_waddr0_o(rf_waddr0_o), .rf_waddr1_o(rf_waddr1_o),
        .rf_wdata0_o(rf_wdata0_o), .rf_wdata1_o(rf_wdata1_o),
        .csr_we_o(csr_we), .csr_waddr_o(csr_waddr), .csr_wdata_o(csr_wdata),
        .llw_scw_o(llw_scw_o), .refetch_o(refetch), .refetch_pc_o(refetch_pc));

    pipe_flush_pause u_flush (
        .excp_i(excp_rec_o.is_excp), .ertn_i(ertn), .refetch_i(refetch),
        .refetch_pc_i(refetch_pc), .branch_flush_i(branch_flush_i),
        .branch_target_i(branch_target_i), .ex_excp_flush_i(ex_excp_flush_i),
        .eentry_i(eentry), .era_i(era), .pause_req_i(pause_req_i), .idle_i(idle),
        .int_taken_i(int_taken), .flush_o(flush_o), .pause_o(pause_o),
        .new_pc_o(new_pc_o));

    commit_csr_regs #(.EENTRY_RST(EENTRY_RST)) u_csr (
        .clk(clk), .arst_n_i(arst_n_i), .excp_rec_i(excp_rec_o), .ertn_i(ertn),
        .csr_we_i(csr_we), .csr_waddr_i(csr_waddr), .csr_wdata_i(csr_wdata),
        .int_pending_i(int_pending_i), .raddr_i(csr_raddr_i), .rdata_o(csr_rdata_o),
        .eentry_o(eentry), .era_o(era), .plv_o(crmd_plv), .int_taken_o(int_taken));

endmodule

`default_nettype wire

// ==== test/tb_commit_tasks.svh ====
// stops the run at the first error
task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first error");
endtask

task automatic compare_vec(input string name, input stage_vec_t got, input stage_vec_t exp);
    if (got !== exp) begin
        $display("MISMATCH %0t ns %s got %b expected %b", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %0t ns %s got %h expected %h", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_rec(input string name, input excp_rec_t got, input excp_rec_t exp);
    if (got !== exp) begin
        $display("MISMATCH %0t ns %s got %h expected %h", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_we(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %0t ns %s got %b expected %b", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH %0t ns %s got %b expected %b", $time, name, got, exp);
        end_with_failure();
    end
endtask

function automatic stage_vec_t flush_model(input logic excp, input logic ertn,
                                           input logic refetch, input logic branch,
                                           input logic ex_excp);
    stage_vec_t v;
    v[0]   = 1'b0; // pc stage never flushed
    v[2:1] = {2{excp | ertn | refetch}};
    v[4:3] = {2{excp | ertn | refetch | branch | ex_excp}};
    v[7:5] = {3{excp | ertn | refetch | branch}};
    return v;
endfunction

// idle here already has the interrupt wake folded in
function automatic stage_vec_t pause_model(input pause_req_t req, input logic idle,
                                           input logic flush1);
    logic [4:0] back;
    if (req.mem || idle) back = 5'b01111;
    else if (req.execute) back = 5'b00111;
    else if (req.dispatch) back = 5'b00011;
    else if (req.decode) back = 5'b00001;
    else back = 5'b00000;
    return {back, req.decode, req.buffer && !flush1, req.buffer};
endfunction

function automatic excp_rec_t rec_model(input logic excp, input excp_cause_e cause,
                                        input logic [31:0] pc, input logic [31:0] badv);
    excp_rec_t   rec;
    logic [14:0] codes;
    rec   = '0;
    codes = ecode_of(cause);
    if (excp) begin
        rec.is_excp  = 1'b1;
        rec.cause    = cause;
        rec.pc       = pc;
        rec.badv     = badv;
        rec.ecode    = codes[14:9];
        rec.esubcode = codes[8:0];
    end
    return rec;
endfunction

function automatic logic [31:0] rand_pc();
    return $urandom() & 32'hFFFF_FFFC; // word aligned
endfunction

task automatic idle_inputs();
    slot0         = '0;
    slot1         = '0;
    pause_req     = '0;
    branch_flush  = 1'b0;
    branch_target = 32'd0;
    ex_excp_flush = 1'b0;
    int_pending   = 1'b0;
    csr_raddr     = CRMD;
endtask

task automatic settle();
    #2; // well before the next rising edge
endtask

task automatic check_csr(input csr_addr_e addr, input logic [31:0] exp, input string name);
    @(negedge clk);
    idle_inputs();
    csr_raddr = addr;
    settle();
    compare_word(name, csr_rdata, exp);
endtask

task automatic test_branch_flush();
    logic [31:0] target;
    target = rand_pc();
    @(negedge clk);
    idle_inputs();
    settle();
    compare_vec("flush_o idle", flush, 8'h00);
    compare_vec("pause_o idle", pause, 8'h00);
    compare_we("rf_we_o idle", rf_we, 2'b00);
    @(negedge clk);
    branch_flush  = 1'b1;
    branch_target = target;
    settle();
    compare_vec("flush_o branch", flush, flush_model(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    compare_word("new_pc_o branch", new_pc, target);
    @(negedge clk);
    branch_flush  = 1'b0;
    ex_excp_flush = 1'b1;
    settle();
    compare_vec("flush_o ex_excp", flush, flush_model(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    compare_word("new_pc_o ex_excp", new_pc, target);
endtask

task automatic test_slot1_exception();
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] addr1;
    logic [14:0] codes;
    pc0   = rand_pc();
    pc1   = pc0 + 32'd4;
    addr1 = $urandom();
    codes = ecode_of(INE);
    @(negedge clk);
    idle_inputs();
    slot0.valid   = 1'b1;
    slot0.pc      = pc0;
    slot0.rf_we   = 1'b1;
    slot0.rf_addr = 5'd5;
    slot0.rf_data = $urandom();
    slot1.valid    = 1'b1;
    slot1.pc       = pc1;
    slot1.mem_addr = addr1;
    slot1.excp_flags     = 6'b001010; // decode flag outranks the mem flag
    slot1.excp_causes[3] = INE;
    slot1.excp_causes[1] = ALE;
    slot1.rf_we   = 1'b1;
    slot1.rf_addr = 5'd6;
    settle();
    compare_rec("excp_rec_o slot1", excp_rec, rec_model(1'b1, INE, pc1, addr1));
    compare_word("new_pc_o excp", new_pc, EENTRY_RST);
    compare_we("rf_we_o slot1 excp", rf_we, 2'b01);
    compare_vec("flush_o excp", flush, flush_model(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    check_csr(ERA, pc1, "csr_rdata_o era");
    check_csr(ESTAT, {17'd0, codes[8:0], codes[14:9]}, "csr_rdata_o estat");
endtask

task automatic test_priv_check();
    logic [31:0] pc;
    pc = rand_pc();
    @(negedge clk);
    idle_inputs();
    slot0.valid    = 1'b1;
    slot0.pc       = pc;
    slot0.csr_we   = 1'b1;
    slot0.csr_addr = CRMD;
    slot0.csr_data = 32'h3; // user mode
    settle();
    check_csr(CRMD, 32'h3, "csr_rdata_o crmd plv");
    @(negedge clk);
    idle_inputs();
    slot0.valid          = 1'b1;
    slot0.pc             = pc;
    slot0.is_priv        = 1'b1;
    slot0.excp_flags     = 6'b001000;
    slot0.excp_causes[3] = BRK;
    settle();
    compare_rec("excp_rec_o ipe", excp_rec, rec_model(1'b1, IPE, pc, 32'd0));
    // exception entry drops plv to 0, same slot again
    @(negedge clk);
    settle();
    compare_rec("excp_rec_o plv0", excp_rec, rec_model(1'b1, BRK, pc, 32'd0));
endtask

task automatic test_interrupt_ertn();
    logic [31:0] pc;
    pc = rand_pc();
    @(negedge clk);
    idle_inputs();
    int_pending = 1'b1;
    slot0.valid = 1'b1;
    slot0.pc    = pc;
    settle();
    compare_rec("excp_rec_o masked int", excp_rec, rec_model(1'b0, NOP, 32'd0, 32'd0));
    @(negedge clk);
    slot0.csr_we   = 1'b1;
    slot0.csr_addr = CRMD;
    slot0.csr_data = 32'h5; // ie set, plv 1
    settle();
    @(negedge clk);
    slot0.csr_we = 1'b0;
    settle();
    compare_rec("excp_rec_o int", excp_rec, rec_model(1'b1, INT, pc, 32'd0));
    @(negedge clk);
    idle_inputs();
    slot0.valid   = 1'b1;
    slot0.pc      = rand_pc();
    slot0.is_ertn = 1'b1;
    settle();
    compare_word("new_pc_o ertn", new_pc, pc);
    compare_bit("is_ertn_o", is_ertn, 1'b1);
    compare_vec("flush_o ertn", flush, flush_model(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    check_csr(CRMD, 32'h5, "csr_rdata_o crmd after ertn");
endtask

task automatic test_pause_priority();
    int          i;
    logic [31:0] rnd;
    for (i = 0; i < 32; i++) begin
        @(negedge clk);
        idle_inputs();
        pause_req = i[4:0];
        settle();
        compare_vec("pause_o req", pause, pause_model(pause_req, 1'b0, 1'b0));
    end
    @(negedge clk);
    idle_inputs();
    rnd = $urandom();
    pause_req     = rnd[4:0];
    slot0.valid   = 1'b1;
    slot0.is_idle = 1'b1;
    settle();
    compare_vec("pause_o idle", pause, pause_model(pause_req, 1'b1, 1'b0));
    @(negedge clk);
    idle_inputs();
    pause_req.buffer = 1'b1;
    slot0.valid      = 1'b1;
    slot0.is_ertn    = 1'b1; // flushes the buffer stage
    settle();
    compare_vec("pause_o ertn", pause, pause_model(pause_req, 1'b0, 1'b1));
    // ie is set again, the interrupt wakes the idle slot
    @(negedge clk);
    idle_inputs();
    pause_req.buffer = 1'b1;
    int_pending      = 1'b1;
    slot0.valid      = 1'b1;
    slot0.is_idle    = 1'b1;
    settle();
    compare_vec("pause_o int wake", pause, pause_model(pause_req, 1'b0, 1'b1));
endtask

task automatic test_write_arbitration();
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] dcsr;
    pc0  = rand_pc();
    pc1  = rand_pc();
    d0   = $urandom();
    d1   = $urandom();
    dcsr = $urandom();
    @(negedge clk);
    idle_inputs();
    slot0.valid   = 1'b1;
    slot0.rf_we   = 1'b1;
    slot0.rf_addr = 5'd7;
    slot0.rf_data = d0;
    slot1.valid   = 1'b1;
    slot1.rf_we   = 1'b1;
    slot1.rf_addr = 5'd7;
    slot1.rf_data = d1;
    settle();
    compare_we("rf_we_o same addr", rf_we, 2'b10);
    compare_word("rf_waddr1_o", {27'd0, rf_waddr1}, 32'd7);
    compare_word("rf_wdata1_o", rf_wdata1, d1);
    @(negedge clk);
    slot1.rf_addr    = 5'd8;
    slot0.is_llw_scw = 1'b1;
    settle();
    compare_we("rf_we_o two addr", rf_we, 2'b11);
    compare_word("rf_waddr0_o", {27'd0, rf_waddr0}, 32'd7);
    compare_word("rf_wdata0_o", rf_wdata0, d0);
    compare_bit("llw_scw_o no excp", llw_scw, 1'b1);
    @(negedge clk);
    idle_inputs();
    slot0.valid    = 1'b1;
    slot0.pc       = pc0;
    slot1.valid    = 1'b1;
    slot1.pc       = pc1;
    slot1.csr_we   = 1'b1;
    slot1.csr_addr = ERA;
    slot1.csr_data = dcsr;
    settle();
    compare_vec("flush_o refetch", flush, flush_model(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    compare_word("new_pc_o refetch", new_pc, (pc0 | pc1) + 32'd4);
    check_csr(ERA, dcsr, "csr_rdata_o era write");
    // exception in slot 0 kills every write
    @(negedge clk);
    idle_inputs();
    slot0.valid          = 1'b1;
    slot0.pc             = pc0;
    slot0.excp_flags     = 6'b000001;
    slot0.excp_causes[0] = SYS;
    slot0.rf_we          = 1'b1;
    slot0.rf_addr        = 5'd9;
    slot1.valid          = 1'b1;
    slot1.pc             = pc1;
    slot1.rf_we          = 1'b1;
    slot1.rf_addr        = 5'd10;
    slot1.is_llw_scw     = 1'b1;
    slot1.csr_we         = 1'b1;
    slot1.csr_addr       = ERA;
    slot1.csr_data       = ~dcsr;
    settle();
    compare_we("rf_we_o slot0 excp", rf_we, 2'b00);
    compare_bit("llw_scw_o slot0 excp", llw_scw, 1'b0);
    compare_rec("excp_rec_o sys", excp_rec, rec_model(1'b1, SYS, pc0, 32'd0));
    check_csr(ERA, pc0, "csr_rdata_o era after excp");
endtask

// ==== test/tb_commit_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_commit_ctrl;
    import commit_pkg::*;

    localparam logic [31:0] EENTRY_RST = 32'h1C00_8000;
    localparam logic [31:0] SEED       = 32'h9d15ccfb;
    localparam int          TEST_STEPS = 70; // falling edges used by the whole sequence
    localparam int          TIMEOUT_NS = TEST_STEPS * 20 * 8;

    logic         clk;
    logic         arst_n;
    commit_slot_t slot0;
    commit_slot_t slot1;
    pause_req_t   pause_req;
    logic         branch_flush;
    logic [31:0]  branch_target;
    logic         ex_excp_flush;
    logic         int_pending;
    csr_addr_e    csr_raddr;

    stage_vec_t   flush;
    stage_vec_t   pause;
    logic [31:0]  new_pc;
    logic         is_ertn;
    logic [1:0]   rf_we;
    logic [4:0]   rf_waddr0;
    logic [4:0]   rf_waddr1;
    logic [31:0]  rf_wdata0;
    logic [31:0]  rf_wdata1;
    logic         llw_scw;
    logic [31:0]  csr_rdata;
    excp_rec_t    excp_rec;

    `include "tb_commit_tasks.svh"

    commit_ctrl_top #(.EENTRY_RST(EENTRY_RST)) i_dut (
        .clk(clk),
        .arst_n_i(arst_n),
        .slot0_i(slot0),
        .slot1_i(slot1),
        .pause_req_i(pause_req),
        .branch_flush_i(branch_flush),
        .branch_target_i(branch_target),
        .ex_excp_flush_i(ex_excp_flush),
        .int_pending_i(int_pending),
        .csr_raddr_i(csr_raddr),
        .flush_o(flush),
        .pause_o(pause),
        .new_pc_o(new_pc),
        .is_ertn_o(is_ertn),
        .rf_we_o(rf_we),
        .rf_waddr0_o(rf_waddr0),
        .rf_waddr1_o(rf_waddr1),
        .rf_wdata0_o(rf_wdata0),
        .rf_wdata1_o(rf_wdata1),
        .llw_scw_o(llw_scw),
        .csr_rdata_o(csr_rdata),
        .excp_rec_o(excp_rec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the test sequence did not complete", TIMEOUT_NS);
        end_with_failure();
    end

    initial begin
        void'($urandom(SEED));
        idle_inputs();
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_branch_flush();
        test_slot1_exception();
        test_priv_check();
        test_interrupt_ertn();
        test_pause_priority();
        test_write_arbitration();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+test
source/commit_pkg.sv
source/excp_prioritizer.sv
source/excp_commit_unit.sv
source/pipe_flush_pause.sv
source/commit_write_filter.sv
source/commit_csr_regs.sv
source/commit_ctrl_top.sv
test/tb_commit_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_commit_ctrl -f all.f -o tb_commit_ctrl \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_commit_ctrl > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
